// File: design/mcu_bus_pkg.sv
// system bus package
// widths, manager count and target codes shared by the OBI fabric
package mcu_bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W = 4;

  // core is manager 0, dma is manager 1
  localparam int NUM_MGR = 2;

  // answer for a read that hits no target
  localparam logic [DATA_W-1:0] ERR_RDATA = 32'hBADCAB1E;

  // bus targets behind the decoder
  localparam logic [1:0] TGT_MEM = 2'd0;
  localparam logic [1:0] TGT_PERIPH = 2'd1;
  localparam logic [1:0] TGT_ERR = 2'd2;

endpackage

// File: design/mcu_map_pkg.sv
// address map package
// regions, register indices, RAM bank geometry and the two address views
package mcu_map_pkg;

  localparam int NUM_BANKS = 4;
  localparam int BANK_WORDS = 2048;
  localparam int NUM_GPIO = 32;
  localparam int REG_IDX_W = 6;

  localparam logic [3:0] RAM_REGION = 4'h0;
  localparam logic [3:0] PERIPH_REGION = 4'h2;

  // peripheral ids, address bits 11:8
  localparam logic [3:0] PERIPH_GPIO = 4'd0;
  localparam logic [3:0] PERIPH_TIMER = 4'd1;

  localparam logic [REG_IDX_W-1:0] GPIO_OUT = 6'd0;
  localparam logic [REG_IDX_W-1:0] GPIO_OE = 6'd1;
  localparam logic [REG_IDX_W-1:0] GPIO_IN = 6'd2;
  localparam logic [REG_IDX_W-1:0] GPIO_INTR_EN = 6'd3;
  localparam logic [REG_IDX_W-1:0] GPIO_INTR_STATUS = 6'd4;

  localparam logic [REG_IDX_W-1:0] TIMER_MTIME = 6'd0;
  localparam logic [REG_IDX_W-1:0] TIMER_CMP = 6'd1;
  localparam logic [REG_IDX_W-1:0] TIMER_CTRL = 6'd2;

  localparam int NUM_GPIO_INTR = 8;
  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_FAST_BASE = 16;

  // one address word, read either as a RAM or as a peripheral address
  typedef union packed {
    struct packed {
      logic [3:0]                      region;
      logic [12:0]                     unused;
      logic [$clog2(NUM_BANKS)-1:0]    bank;
      logic [$clog2(BANK_WORDS)-1:0]   word;
      logic [1:0]                      offset;
    } ram;
    struct packed {
      logic [3:0]           region;
      logic [15:0]          unused;
      logic [3:0]           periph_id;
      logic [REG_IDX_W-1:0] reg_idx;
      logic [1:0]           offset;
    } periph;
  } mcu_addr_u;

endpackage

// File: design/obi_bus_if.sv
// OBI request/grant bus
// response comes one cycle after the grant, never back-pressured
`timescale 1ns/1ps

interface obi_bus_if
  import mcu_bus_pkg::*;
();

  logic              req;
  logic              gnt;
  logic [ADDR_W-1:0] addr;
  logic              we;
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] wdata;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;

  modport manager(output req, addr, we, be, wdata, input gnt, rvalid, rdata);

  modport subordinate(input req, addr, we, be, wdata, output gnt, rvalid, rdata);

endinterface

// File: design/reg_bus_if.sv
// register access bus from the peripheral decoder to one peripheral
`timescale 1ns/1ps

interface reg_bus_if
  import mcu_bus_pkg::*, mcu_map_pkg::*;
();

  logic                 valid;
  logic                 we;
  logic [REG_IDX_W-1:0] idx;
  logic [DATA_W-1:0]    wdata;
  logic [DATA_W-1:0]    rdata;

  modport host(output valid, we, idx, wdata, input rdata);

  modport peripheral(input valid, we, idx, wdata, output rdata);

endinterface

// File: design/gpio_ctrl.sv
// GPIO controller
// output and enable registers, synchronized inputs, rising-edge interrupts
`timescale 1ns/1ps

module gpio_ctrl
  import mcu_bus_pkg::*, mcu_map_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  reg_bus_if.peripheral            regs,
  input  logic [NUM_GPIO-1:0]      gpio_i,
  output logic [NUM_GPIO-1:0]      gpio_o,
  output logic [NUM_GPIO-1:0]      gpio_oe_o,
  output logic [NUM_GPIO_INTR-1:0] intr_o
);

  logic [NUM_GPIO-1:0]      out_q;
  logic [NUM_GPIO-1:0]      oe_q;
  logic [NUM_GPIO-1:0]      in_meta_q;
  logic [NUM_GPIO-1:0]      in_sync_q;
  logic [NUM_GPIO_INTR-1:0] intr_pins;
  logic [NUM_GPIO_INTR-1:0] prev_q;
  logic [NUM_GPIO_INTR-1:0] en_q;
  logic [NUM_GPIO_INTR-1:0] status_q;
  logic [NUM_GPIO_INTR-1:0] rise;
  logic [NUM_GPIO_INTR-1:0] clr;
  logic                     wr;

  assign wr = regs.valid && regs.we;
  assign intr_pins = in_sync_q[NUM_GPIO_INTR-1:0];
  assign rise = intr_pins & ~prev_q;
  // write one to clear
  assign clr = (wr && regs.idx == GPIO_INTR_STATUS) ? regs.wdata[NUM_GPIO_INTR-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      in_meta_q <= '0;
      in_sync_q <= '0;
      prev_q    <= '0;
      en_q      <= '0;
      status_q  <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      prev_q    <= intr_pins;
      // a new edge wins over a clear in the same cycle
      status_q  <= (status_q & ~clr) | rise;
      if (wr && regs.idx == GPIO_OUT) out_q <= regs.wdata;
      if (wr && regs.idx == GPIO_OE) oe_q <= regs.wdata;
      if (wr && regs.idx == GPIO_INTR_EN) en_q <= regs.wdata[NUM_GPIO_INTR-1:0];
    end
  end

  always_comb begin
    case (regs.idx)
      GPIO_OUT:         regs.rdata = out_q;
      GPIO_OE:          regs.rdata = oe_q;
      GPIO_IN:          regs.rdata = in_sync_q;
      GPIO_INTR_EN:     regs.rdata = DATA_W'(en_q);
      GPIO_INTR_STATUS: regs.rdata = DATA_W'(status_q);
      default:          regs.rdata = '0;
    endcase
  end

  assign gpio_o = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o = status_q & en_q;

  // status only rises after a 0 to 1 step of the synchronized pin
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (status_q & ~$past(status_q) & ~($past(intr_pins) & ~$past(intr_pins, 2))) == '0);

endmodule

// File: design/machine_timer.sv
// machine timer
// free-running 32-bit time counter with a compare interrupt
`timescale 1ns/1ps

module machine_timer
  import mcu_bus_pkg::*, mcu_map_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  reg_bus_if.peripheral regs,
  output logic          intr_o
);

  logic [DATA_W-1:0] mtime_q;
  logic [DATA_W-1:0] cmp_q;
  logic              en_q;
  logic              intr_q;
  logic              wr;

  assign wr = regs.valid && regs.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtime_q <= '0;
      cmp_q   <= '0;
      en_q    <= 1'b0;
      intr_q  <= 1'b0;
    end else begin
      // a software write to mtime overrides the count
      if (wr && regs.idx == TIMER_MTIME) begin
        mtime_q <= regs.wdata;
      end else if (en_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr && regs.idx == TIMER_CMP) cmp_q <= regs.wdata;
      if (wr && regs.idx == TIMER_CTRL) en_q <= regs.wdata[0];
      intr_q <= en_q && (mtime_q >= cmp_q);
    end
  end

  always_comb begin
    case (regs.idx)
      TIMER_MTIME: regs.rdata = mtime_q;
      TIMER_CMP:   regs.rdata = cmp_q;
      TIMER_CTRL:  regs.rdata = DATA_W'(en_q);
      default:     regs.rdata = '0;
    endcase
  end

  assign intr_o = intr_q;

endmodule

// File: design/memory_subsystem.sv
// banked on-chip RAM
// byte-enable writes, read data one cycle after the grant
`timescale 1ns/1ps

module memory_subsystem
  import mcu_bus_pkg::*, mcu_map_pkg::*;
(
  input logic            clk_i,
  input logic            rst_n_i,
  obi_bus_if.subordinate bus
);

  logic [DATA_W-1:0] ram[NUM_BANKS][BANK_WORDS];
  mcu_addr_u         addr;
  logic              access;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  assign addr = bus.addr;
  assign bus.gnt = bus.req;
  assign access = bus.req && bus.gnt;

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (bus.we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (bus.be[b]) begin
            ram[addr.ram.bank][addr.ram.word][8*b+:8] <= bus.wdata[8*b+:8];
          end
        end
      end
      rdata_q <= ram[addr.ram.bank][addr.ram.word];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata = rdata_q;

endmodule

// File: design/peripheral_subsystem.sv
// peripheral subsystem
// register decode for GPIO and timer, interrupt vector assembly
`timescale 1ns/1ps

module peripheral_subsystem
  import mcu_bus_pkg::*, mcu_map_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  obi_bus_if.subordinate      bus,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic [31:0]         irq_o
);

  reg_bus_if gpio_regs ();
  reg_bus_if timer_regs ();

  mcu_addr_u               addr;
  logic                    access;
  logic [DATA_W-1:0]       rdata_sel;
  logic                    rvalid_q;
  logic [DATA_W-1:0]       rdata_q;
  logic [NUM_GPIO_INTR-1:0] gpio_intr;
  logic                    timer_intr;

  assign addr = bus.addr;
  assign bus.gnt = bus.req;
  assign access = bus.req && bus.gnt;

  assign gpio_regs.valid = access && addr.periph.periph_id == PERIPH_GPIO;
  assign gpio_regs.we = bus.we;
  assign gpio_regs.idx = addr.periph.reg_idx;
  assign gpio_regs.wdata = bus.wdata;

  assign timer_regs.valid = access && addr.periph.periph_id == PERIPH_TIMER;
  assign timer_regs.we = bus.we;
  assign timer_regs.idx = addr.periph.reg_idx;
  assign timer_regs.wdata = bus.wdata;

  always_comb begin
    case (addr.periph.periph_id)
      PERIPH_GPIO:  rdata_sel = gpio_regs.rdata;
      PERIPH_TIMER: rdata_sel = timer_regs.rdata;
      default:      rdata_sel = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata = rdata_q;

  gpio_ctrl u_gpio (
    .clk_i,
    .rst_n_i,
    .regs     (gpio_regs.peripheral),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .intr_o   (gpio_intr)
  );

  machine_timer u_timer (
    .clk_i,
    .rst_n_i,
    .regs   (timer_regs.peripheral),
    .intr_o (timer_intr)
  );

  // timer on the machine timer line, gpio on the fast lines
  always_comb begin
    irq_o = '0;
    irq_o[IRQ_TIMER_BIT] = timer_intr;
    irq_o[IRQ_FAST_BASE+:NUM_GPIO_INTR] = gpio_intr;
  end

endmodule

// File: design/system_bus.sv
// system bus
// round-robin arbitration of core and dma, address decode to RAM, peripherals or error
`timescale 1ns/1ps

module system_bus
  import mcu_bus_pkg::*, mcu_map_pkg::*;
(
  input logic            clk_i,
  input logic            rst_n_i,
  obi_bus_if.subordinate core_bus,
  obi_bus_if.subordinate dma_bus,
  obi_bus_if.manager     mem_bus,
  obi_bus_if.manager     periph_bus
);

  obi_bus_if err_bus ();

  logic [NUM_MGR-1:0] mgr_req;
  logic [NUM_MGR-1:0] mgr_gnt;
  logic [NUM_MGR-1:0] mgr_rvalid;
  logic               win_idx;
  logic               last_q;
  mcu_addr_u          win_addr;
  logic [1:0]         tgt;
  logic               tgt_gnt;
  logic               rsp_mgr_q;
  logic [1:0]         rsp_tgt_q;
  logic               rsp_valid;
  logic [DATA_W-1:0]  rsp_data;
  logic               err_rvalid_q;

  assign mgr_req = {dma_bus.req, core_bus.req};

  // on a tie the manager not granted last wins
  assign win_idx = (&mgr_req) ? ~last_q : mgr_req[1];
  assign win_addr = win_idx ? dma_bus.addr : core_bus.addr;

  always_comb begin
    tgt = TGT_ERR;
    if (win_addr.ram.region == RAM_REGION && win_addr.ram.unused == '0) begin
      tgt = TGT_MEM;
    end else if (win_addr.periph.region == PERIPH_REGION) begin
      tgt = TGT_PERIPH;
    end
  end

  assign mem_bus.req = (|mgr_req) && tgt == TGT_MEM;
  assign periph_bus.req = (|mgr_req) && tgt == TGT_PERIPH;
  assign err_bus.req = (|mgr_req) && tgt == TGT_ERR;

  assign mem_bus.addr = win_addr;
  assign mem_bus.we = win_idx ? dma_bus.we : core_bus.we;
  assign mem_bus.be = win_idx ? dma_bus.be : core_bus.be;
  assign mem_bus.wdata = win_idx ? dma_bus.wdata : core_bus.wdata;
  assign periph_bus.addr = win_addr;
  assign periph_bus.we = mem_bus.we;
  assign periph_bus.be = mem_bus.be;
  assign periph_bus.wdata = mem_bus.wdata;

  // unmapped accesses are accepted and answered with a marker word
  assign err_bus.gnt = err_bus.req;
  assign err_bus.rvalid = err_rvalid_q;
  assign err_bus.rdata = ERR_RDATA;

  assign tgt_gnt = (mem_bus.req && mem_bus.gnt) || (periph_bus.req && periph_bus.gnt) ||
                   (err_bus.req && err_bus.gnt);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q       <= 1'b0;
      rsp_mgr_q    <= 1'b0;
      rsp_tgt_q    <= TGT_ERR;
      err_rvalid_q <= 1'b0;
    end else begin
      err_rvalid_q <= err_bus.req && err_bus.gnt;
      if (tgt_gnt) begin
        last_q    <= win_idx;
        rsp_mgr_q <= win_idx;
        rsp_tgt_q <= tgt;
      end
    end
  end

  // route the response back to the manager granted last cycle
  always_comb begin
    case (rsp_tgt_q)
      TGT_MEM: begin
        rsp_valid = mem_bus.rvalid;
        rsp_data  = mem_bus.rdata;
      end
      TGT_PERIPH: begin
        rsp_valid = periph_bus.rvalid;
        rsp_data  = periph_bus.rdata;
      end
      default: begin
        rsp_valid = err_bus.rvalid;
        rsp_data  = err_bus.rdata;
      end
    endcase
  end

  for (genvar i = 0; i < NUM_MGR; i++) begin : g_mgr
    assign mgr_gnt[i] = tgt_gnt && win_idx == i;
    assign mgr_rvalid[i] = rsp_valid && rsp_mgr_q == i;

    assert property (@(posedge clk_i) disable iff (!rst_n_i) mgr_gnt[i] |-> mgr_req[i]);
    assert property (@(posedge clk_i) disable iff (!rst_n_i) mgr_gnt[i] |=> mgr_rvalid[i]);
  end

  assign core_bus.gnt = mgr_gnt[0];
  assign dma_bus.gnt = mgr_gnt[1];
  assign core_bus.rvalid = mgr_rvalid[0];
  assign dma_bus.rvalid = mgr_rvalid[1];
  assign core_bus.rdata = rsp_data;
  assign dma_bus.rdata = rsp_data;

endmodule

// File: design/mini_mcu.sv
// mini MCU top level
// core and dma ports share one system bus to RAM, GPIO and timer
`timescale 1ns/1ps

module mini_mcu
  import mcu_bus_pkg::*, mcu_map_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  logic                core_req_i,
  input  logic [ADDR_W-1:0]   core_addr_i,
  input  logic                core_we_i,
  input  logic [BE_W-1:0]     core_be_i,
  input  logic [DATA_W-1:0]   core_wdata_i,
  output logic                core_gnt_o,
  output logic                core_rvalid_o,
  output logic [DATA_W-1:0]   core_rdata_o,

  input  logic                dma_req_i,
  input  logic [ADDR_W-1:0]   dma_addr_i,
  input  logic                dma_we_i,
  input  logic [BE_W-1:0]     dma_be_i,
  input  logic [DATA_W-1:0]   dma_wdata_i,
  output logic                dma_gnt_o,
  output logic                dma_rvalid_o,
  output logic [DATA_W-1:0]   dma_rdata_o,

  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic [31:0]         irq_o
);

  obi_bus_if core_if ();
  obi_bus_if dma_if ();
  obi_bus_if mem_if ();
  obi_bus_if periph_if ();

  // manager ports onto the bus
  assign core_if.req = core_req_i;
  assign core_if.addr = core_addr_i;
  assign core_if.we = core_we_i;
  assign core_if.be = core_be_i;
  assign core_if.wdata = core_wdata_i;
  assign core_gnt_o = core_if.gnt;
  assign core_rvalid_o = core_if.rvalid;
  assign core_rdata_o = core_if.rdata;

  assign dma_if.req = dma_req_i;
  assign dma_if.addr = dma_addr_i;
  assign dma_if.we = dma_we_i;
  assign dma_if.be = dma_be_i;
  assign dma_if.wdata = dma_wdata_i;
  assign dma_gnt_o = dma_if.gnt;
  assign dma_rvalid_o = dma_if.rvalid;
  assign dma_rdata_o = dma_if.rdata;

  system_bus u_system_bus (
    .clk_i,
    .rst_n_i,
    .core_bus   (core_if.subordinate),
    .dma_bus    (dma_if.subordinate),
    .mem_bus    (mem_if.manager),
    .periph_bus (periph_if.manager)
  );

  memory_subsystem u_memory_subsystem (
    .clk_i,
    .rst_n_i,
    .bus (mem_if.subordinate)
  );

  peripheral_subsystem u_peripheral_subsystem (
    .clk_i,
    .rst_n_i,
    .bus       (periph_if.subordinate),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .irq_o
  );

endmodule

// File: dv/tb_mini_mcu.sv
// mini MCU testbench
// directed tests of RAM, arbitration, GPIO, timer and unmapped access
`timescale 1ns/1ps

module tb_mini_mcu
  import mcu_bus_pkg::*, mcu_map_pkg::*;
();

  localparam int MAX_CYCLES = 5000;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        core_req_i, core_we_i, core_gnt_o, core_rvalid_o;
  logic [31:0] core_addr_i, core_wdata_i, core_rdata_o;
  logic [3:0]  core_be_i;
  logic        dma_req_i, dma_we_i, dma_gnt_o, dma_rvalid_o;
  logic [31:0] dma_addr_i, dma_wdata_i, dma_rdata_o;
  logic [3:0]  dma_be_i;
  logic [31:0] gpio_i, gpio_o, gpio_oe_o, irq_o;

  int          seed = 32'h947125ab;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  int          last_mgr = -1;
  logic [31:0] ref_mem [int unsigned];

  mini_mcu dut (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] reg_addr(input int id, input int idx);
    return 32'h2000_0000 | (id << 8) | (idx << 2);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b+:8] = new_w[8*b+:8];
    end
    return res;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
  endtask

  // one OBI transfer from manager 0 (core) or 1 (dma)
  task automatic bus_xfer(input int mgr, input logic [31:0] addr, input logic we,
                          input logic [3:0] be, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    logic granted;
    logic other_req;
    logic rv;
    @(posedge clk_i);
    #1;
    if (mgr == 0) begin
      core_req_i = 1'b1;
      core_addr_i = addr;
      core_we_i = we;
      core_be_i = be;
      core_wdata_i = wdata;
    end else begin
      dma_req_i = 1'b1;
      dma_addr_i = addr;
      dma_we_i = we;
      dma_be_i = be;
      dma_wdata_i = wdata;
    end
    granted = 1'b0;
    other_req = 1'b0;
    while (!granted) begin
      @(negedge clk_i);
      granted = (mgr == 0) ? core_gnt_o : dma_gnt_o;
      other_req = (mgr == 0) ? dma_req_i : core_req_i;
    end
    // contested grant goes to the manager not granted last
    if (other_req && last_mgr == mgr) begin
      errors++;
      $display("manager %0d won a contested grant twice in a row", mgr);
    end
    last_mgr = mgr;
    @(posedge clk_i);
    #1;
    if (mgr == 0) core_req_i = 1'b0;
    else dma_req_i = 1'b0;
    @(negedge clk_i);
    rv = (mgr == 0) ? core_rvalid_o : dma_rvalid_o;
    rdata = (mgr == 0) ? core_rdata_o : dma_rdata_o;
    if (!rv) begin
      errors++;
      $display("manager %0d saw no rvalid one cycle after its grant at 0x%08h", mgr, addr);
    end
  endtask

  task automatic write_word(input int mgr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
    logic [31:0] unused_rd;
    bus_xfer(mgr, addr, 1'b1, be, data, unused_rd);
  endtask

  task automatic read_word(input int mgr, input logic [31:0] addr, output logic [31:0] data);
    bus_xfer(mgr, addr, 1'b0, 4'hF, 32'h0, data);
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_passed++;
      $display("[%s] ok", name);
    end else begin
      tests_failed++;
      $display("[%s] FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic ram_access_test();
    int          err0;
    logic [31:0] addrs[$];
    logic [31:0] a, d, rd;
    logic [3:0]  be;
    err0 = errors;
    for (int bank = 0; bank < 4; bank++) begin
      for (int k = 0; k < 3; k++) begin
        a = (bank << 13) | (($random(seed) & 32'h7FF) << 2);
        d = $random(seed);
        write_word(0, a, d, 4'hF);
        ref_mem[a] = d;
        addrs.push_back(a);
      end
    end
    foreach (addrs[i]) begin
      d = $random(seed);
      be = $random(seed);
      write_word(0, addrs[i], d, be);
      ref_mem[addrs[i]] = merge_bytes(ref_mem[addrs[i]], d, be);
    end
    foreach (addrs[i]) begin
      read_word(0, addrs[i], rd);
      if (rd !== ref_mem[addrs[i]]) report_mismatch("core_rdata_o", rd, ref_mem[addrs[i]]);
    end
    finish_test("ram_access", err0);
  endtask

  task automatic arbitration_test();
    int          err0;
    logic [31:0] ca, da, cd, dd, crd, drd;
    err0 = errors;
    for (int r = 0; r < 6; r++) begin
      ca = 32'h0000_0100 + r * 4;
      da = 32'h0000_6000 + r * 4;
      cd = $random(seed);
      dd = $random(seed);
      fork
        write_word(0, ca, cd, 4'hF);
        write_word(1, da, dd, 4'hF);
      join
      ref_mem[ca] = cd;
      ref_mem[da] = dd;
    end
    for (int r = 0; r < 6; r++) begin
      ca = 32'h0000_0100 + r * 4;
      da = 32'h0000_6000 + r * 4;
      fork
        read_word(0, ca, crd);
        read_word(1, da, drd);
      join
      if (crd !== ref_mem[ca]) report_mismatch("core_rdata_o", crd, ref_mem[ca]);
      if (drd !== ref_mem[da]) report_mismatch("dma_rdata_o", drd, ref_mem[da]);
    end
    finish_test("arbitration", err0);
  endtask

  task automatic gpio_io_test();
    int          err0;
    logic [31:0] out_v, oe_v, in_v, rd;
    err0 = errors;
    out_v = $random(seed);
    oe_v = $random(seed);
    write_word(0, reg_addr(PERIPH_GPIO, GPIO_OUT), out_v, 4'hF);
    write_word(0, reg_addr(PERIPH_GPIO, GPIO_OE), oe_v, 4'hF);
    if (gpio_o !== out_v) report_mismatch("gpio_o", gpio_o, out_v);
    if (gpio_oe_o !== oe_v) report_mismatch("gpio_oe_o", gpio_oe_o, oe_v);
    in_v = $random(seed);
    @(posedge clk_i);
    #1;
    gpio_i = in_v;
    repeat (4) @(posedge clk_i);
    read_word(0, reg_addr(PERIPH_GPIO, GPIO_IN), rd);
    if (rd !== in_v) report_mismatch("GPIO_IN", rd, in_v);
    finish_test("gpio_io", err0);
  endtask

  task automatic gpio_irq_test();
    int   err0;
    int   waited;
    logic [7:0] en_mask;
    err0 = errors;
    en_mask = 8'h5A;
    @(posedge clk_i);
    #1;
    gpio_i[7:0] = 8'h00;
    repeat (4) @(posedge clk_i);
    write_word(0, reg_addr(PERIPH_GPIO, GPIO_INTR_STATUS), 32'hFF, 4'hF);
    write_word(0, reg_addr(PERIPH_GPIO, GPIO_INTR_EN), {24'h0, en_mask}, 4'hF);
    @(posedge clk_i);
    #1;
    gpio_i[7:0] = 8'hFF;
    waited = 0;
    while (irq_o[23:16] == 8'h00 && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    if (irq_o[23:16] == 8'h00) begin
      errors++;
      $display("GPIO interrupt did not rise within 8 cycles of the pin edge");
    end
    @(negedge clk_i);
    if (irq_o[23:16] !== en_mask) report_mismatch("irq_o[23:16]", irq_o[23:16], en_mask);
    write_word(0, reg_addr(PERIPH_GPIO, GPIO_INTR_STATUS), 32'hFF, 4'hF);
    if (irq_o[23:16] !== 8'h00) report_mismatch("irq_o[23:16]", irq_o[23:16], 8'h00);
    finish_test("gpio_irq", err0);
  endtask

  task automatic timer_test();
    int          err0;
    int          waited;
    logic [31:0] rd;
    err0 = errors;
    write_word(0, reg_addr(PERIPH_TIMER, TIMER_MTIME), 32'd0, 4'hF);
    write_word(0, reg_addr(PERIPH_TIMER, TIMER_CMP), 32'd50, 4'hF);
    write_word(0, reg_addr(PERIPH_TIMER, TIMER_CTRL), 32'd1, 4'hF);
    if (irq_o[7] !== 1'b0) report_mismatch("irq_o[7]", irq_o[7], 1'b0);
    waited = 0;
    while (!irq_o[7] && waited < 60) begin
      @(negedge clk_i);
      waited++;
    end
    if (!irq_o[7]) begin
      errors++;
      $display("timer interrupt did not rise within 60 cycles");
    end
    // gpio status was cleared, so only the timer line is up
    if (irq_o !== 32'h0000_0080) report_mismatch("irq_o", irq_o, 32'h0000_0080);
    read_word(0, reg_addr(PERIPH_TIMER, TIMER_MTIME), rd);
    if (rd <= 32'd50) begin
      errors++;
      $display("MISMATCH TIMER_MTIME: got 0x%08h expected above 0x%08h", rd, 32'd50);
    end
    write_word(0, reg_addr(PERIPH_TIMER, TIMER_CMP), rd + 32'd100000, 4'hF);
    repeat (2) @(negedge clk_i);
    if (irq_o[7] !== 1'b0) report_mismatch("irq_o[7]", irq_o[7], 1'b0);
    write_word(0, reg_addr(PERIPH_TIMER, TIMER_CTRL), 32'd0, 4'hF);
    finish_test("timer", err0);
  endtask

  task automatic unmapped_test();
    int          err0;
    logic [31:0] rd;
    err0 = errors;
    read_word(0, 32'h1000_0000, rd);
    if (rd !== 32'hBADCAB1E) report_mismatch("core_rdata_o", rd, 32'hBADCAB1E);
    if (irq_o !== 32'h0) report_mismatch("irq_o", irq_o, 32'h0);
    finish_test("unmapped", err0);
  endtask

  initial begin
    rst_n_i = 1'b0;
    core_req_i = 1'b0;
    core_addr_i = '0;
    core_we_i = 1'b0;
    core_be_i = '0;
    core_wdata_i = '0;
    dma_req_i = 1'b0;
    dma_addr_i = '0;
    dma_we_i = 1'b0;
    dma_be_i = '0;
    dma_wdata_i = '0;
    gpio_i = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    ram_access_test();
    arbitration_test();
    gpio_io_test();
    gpio_irq_test();
    timer_test();
    unmapped_test();
    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: build.f
design/mcu_bus_pkg.sv
design/mcu_map_pkg.sv
design/obi_bus_if.sv
design/reg_bus_if.sv
design/gpio_ctrl.sv
design/machine_timer.sv
design/memory_subsystem.sv
design/peripheral_subsystem.sv
design/system_bus.sv
design/mini_mcu.sv
dv/tb_mini_mcu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mini MCU testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_mini_mcu \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
exit 1
